// ==== secv_mem.f ====
common/secv_pkg.sv
hw/mem/mtag_chk.sv
hw/mem/mem.sv
hw/dmem_ram.sv
hw/tmem_ram.sv
hw/secv_mem_top.sv
tb/secv_mem_props.sv
tb/tb_secv_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f secv_mem.f --top-module tb_secv_mem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_secv_mem +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// ==== tb/tb_secv_mem.sv ====
// Testbench for the tagged memory unit, random loads and stores checked against a model
`timescale 1ns/1ps

module tb_secv_mem;

    localparam int N_NARROW = 40;
    localparam int N_TAG    = 40;
    localparam int N_RAND   = 400;
    localparam int N_OPS    = 256 + 2 * N_NARROW + 2 * N_TAG + N_RAND + 5;
    localparam int WATCHDOG_CYCLES = N_OPS * 60;

    logic                 clk;
    logic                 rst;
    secv_pkg::funit_in_t  fu;
    secv_pkg::funit_out_t fu_o;
    logic                 tag_err;
    secv_pkg::tag_wr_t    tag_wr;

    // Reference model of data words and tags
    logic [63:0] mem_model [256];
    logic [15:0] tag_model [256];

    // Expected response of the operation in flight
    int          exp_lat;
    logic        exp_err;
    logic        exp_tag_err;
    logic        exp_wb;
    logic [63:0] exp_res;
    int          cyc_cnt = 0;

    secv_mem_top dut0 (
        .clk_i     (clk),
        .rst_i     (rst),
        .fu_i      (fu),
        .fu_o      (fu_o),
        .tag_err_o (tag_err),
        .tag_wr_i  (tag_wr)
    );

    bind mem secv_mem_props props0 (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .fu_i   (fu_i),
        .dmem_o (dmem_o),
        .dmem_i (dmem_i),
        .tmem_o (tmem_o),
        .tmem_i (tmem_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal;
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    // Load result from the low lanes of a word
    function automatic logic [63:0] load_value(input logic [3:0] code, input logic [63:0] w);
        case (code)
            4'd0: return {{56{w[7]}}, w[7:0]};
            4'd1: return {{48{w[15]}}, w[15:0]};
            4'd2: return {{32{w[31]}}, w[31:0]};
            4'd3: return w;
            4'd4: return {56'h0, w[7:0]};
            4'd5: return {48'h0, w[15:0]};
            4'd6: return {32'h0, w[31:0]};
            default: return 64'h0;
        endcase
    endfunction

    function automatic logic [63:0] store_merge(input logic [3:0] code, input logic [63:0] old,
                                               input logic [63:0] d);
        case (code)
            4'd7: return {old[63:8], d[7:0]};
            4'd8: return {old[63:16], d[15:0]};
            4'd9: return {old[63:32], d[31:0]};
            4'd10: return d;
            default: return old;
        endcase
    endfunction

    task automatic write_tag(input logic [7:0] adr, input logic [15:0] tag);
        @(posedge clk);
        tag_wr.we  <= 1'b1;
        tag_wr.adr <= adr;
        tag_wr.dat <= tag;
        @(posedge clk);
        tag_wr.we <= 1'b0;
        tag_model[adr] = tag;
    endtask

    task automatic run_op(input logic [3:0] code, input logic [7:0] adr,
                          input logic [15:0] ptag, input logic [63:0] data);
        logic        legal;
        logic        match;
        logic [63:0] mid;
        legal = (code <= 4'd10);
        match = (ptag == tag_model[adr]);
        mid   = rand64();
        @(posedge clk);
        fu.ena      <= 1'b1;
        fu.op       <= secv_pkg::mem_op_t'(code);
        fu.src1     <= {ptag, mid[47:8], adr};
        fu.src2     <= data;
        exp_lat     <= !legal ? 0 : (match ? 3 : 2);
        exp_err     <= !legal || !match;
        exp_tag_err <= legal && !match;
        exp_wb      <= legal && match && (code <= 4'd6);
        exp_res     <= load_value(code, mem_model[adr]);
        do begin
            @(posedge clk);
        end while (!fu_o.rdy);
        fu.ena <= 1'b0;
        if (legal && match) begin
            mem_model[adr] = store_merge(code, mem_model[adr], data);
        end
    endtask

    // Cycles since enable rose, zero in the enable cycle
    always @(posedge clk) begin
        if (fu.ena) begin
            cyc_cnt <= cyc_cnt + 1;
        end else begin
            cyc_cnt <= 0;
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (rst)
        !fu.ena |-> !fu_o.rdy && !fu_o.err && !fu_o.res_wb && !tag_err)
        else stop_with_fail($sformatf("Fail at %0t: outputs active with enable low", $time));

    a_latency: assert property (@(posedge clk) disable iff (rst)
        fu_o.rdy |-> cyc_cnt == exp_lat)
        else stop_with_fail($sformatf("Fail at %0t: rdy in cycle %0d, expected %0d",
                                      $time, cyc_cnt, exp_lat));

    a_status: assert property (@(posedge clk) disable iff (rst)
        fu_o.rdy |-> fu_o.err == exp_err && tag_err == exp_tag_err && fu_o.res_wb == exp_wb)
        else stop_with_fail($sformatf("Fail at %0t: err %b tag_err %b res_wb %b, expected %b %b %b",
                                      $time, fu_o.err, tag_err, fu_o.res_wb,
                                      exp_err, exp_tag_err, exp_wb));

    a_result: assert property (@(posedge clk) disable iff (rst)
        fu_o.rdy && exp_wb |-> fu_o.res == exp_res)
        else stop_with_fail($sformatf("Fail at %0t: res %h, expected %h",
                                      $time, fu_o.res, exp_res));

    always @(posedge clk) begin
        if (dut0.mem0.props0.fail_cnt != 0) begin
            stop_with_fail("A bound bus assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 8);
        stop_with_fail($sformatf("Timeout, run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        logic [7:0]  a;
        logic [3:0]  code;
        logic [15:0] t;
        fu     = '0;
        tag_wr = '0;
        rst    = 1'b1;
        void'($urandom(32'h5b80));
        foreach (tag_model[i]) begin
            tag_model[i] = 16'h0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Fill every word so loads never see unknown data
        for (int i = 0; i < 256; i++) begin
            run_op(4'd10, 8'(i), 16'h0, rand64());
        end
        // Narrow store then a full load of the same word
        for (int i = 0; i < N_NARROW; i++) begin
            a    = 8'($urandom_range(255, 0));
            code = 4'($urandom_range(9, 7));
            run_op(code, a, tag_model[a], rand64());
            run_op(4'd3, a, tag_model[a], rand64());
        end
        // Mismatching pointer tag, then a matching load
        for (int i = 0; i < N_TAG; i++) begin
            a    = 8'($urandom_range(255, 0));
            t    = 16'($urandom());
            code = 4'($urandom_range(10, 0));
            write_tag(a, t);
            run_op(code, a, t ^ (16'h1 << $urandom_range(15, 0)), rand64());
            run_op(4'd3, a, t, rand64());
        end
        for (int i = 0; i < N_RAND; i++) begin
            a    = 8'($urandom_range(255, 0));
            code = 4'($urandom_range(10, 0));
            run_op(code, a, tag_model[a], rand64());
        end
        for (int i = 11; i < 16; i++) begin
            a = 8'($urandom_range(255, 0));
            run_op(4'(i), a, tag_model[a], rand64());
        end

        @(posedge clk);
        if (dut0.mem0.props0.fail_cnt != 0) begin
            stop_with_fail("A bound bus assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== tb/secv_mem_props.sv ====
// Bus and handshake checks bound into the memory unit
`timescale 1ns/1ps

module secv_mem_props (
    input logic                   clk_i,
    input logic                   rst_i,
    input secv_pkg::funit_in_t    fu_i,
    input secv_pkg::dmem_req_t    dmem_o,
    input secv_pkg::dmem_rsp_t    dmem_i,
    input secv_pkg::tmem_req_t    tmem_o,
    input secv_pkg::tmem_rsp_t    tmem_i
);

    // Number of failed bus checks
    int unsigned fail_cnt = 0;

    a_dmem_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_o.stb |-> dmem_o.cyc)
        else begin
            fail_cnt++;
            $error("data stb high without cyc");
        end

    a_tmem_stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        tmem_o.stb |-> tmem_o.cyc)
        else begin
            fail_cnt++;
            $error("tag stb high without cyc");
        end

    // Each acknowledge lasts a single cycle
    a_dmem_ack_once: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_i.ack |=> !dmem_i.ack)
        else begin
            fail_cnt++;
            $error("data ack longer than one cycle");
        end

    a_tmem_ack_once: assert property (@(posedge clk_i) disable iff (rst_i)
        tmem_i.ack |=> !tmem_i.ack)
        else begin
            fail_cnt++;
            $error("tag ack longer than one cycle");
        end

    // Ack follows the first unacknowledged strobe cycle
    a_dmem_ack_next: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_o.stb && !dmem_i.ack |=> dmem_i.ack)
        else begin
            fail_cnt++;
            $error("data ack missing after strobe");
        end

    a_tmem_ack_next: assert property (@(posedge clk_i) disable iff (rst_i)
        tmem_o.stb && !tmem_i.ack |=> tmem_i.ack)
        else begin
            fail_cnt++;
            $error("tag ack missing after strobe");
        end

    // Data access starts two cycles after enable rises
    a_data_start: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(dmem_o.stb) |-> $past(fu_i.ena, 2) && !$past(fu_i.ena, 3))
        else begin
            fail_cnt++;
            $error("data strobe not in the third cycle of the operation");
        end

endmodule

// ==== hw/secv_mem_top.sv ====
// Top level joining the memory function unit with its data and tag memory models
`timescale 1ns/1ps

module secv_mem_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  secv_pkg::funit_in_t    fu_i,
    output secv_pkg::funit_out_t   fu_o,
    output logic                   tag_err_o,
    input  secv_pkg::tag_wr_t      tag_wr_i
);

    secv_pkg::dmem_req_t dmem_req;
    secv_pkg::dmem_rsp_t dmem_rsp;
    secv_pkg::tmem_req_t tmem_req;
    secv_pkg::tmem_rsp_t tmem_rsp;

    mem mem0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .fu_i      (fu_i),
        .fu_o      (fu_o),
        .tag_err_o (tag_err_o),
        .dmem_o    (dmem_req),
        .dmem_i    (dmem_rsp),
        .tmem_o    (tmem_req),
        .tmem_i    (tmem_rsp)
    );

    dmem_ram dmem_ram0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus_i (dmem_req),
        .bus_o (dmem_rsp)
    );

    // Tags are loaded from outside through the side port
    tmem_ram tmem_ram0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus_i (tmem_req),
        .bus_o (tmem_rsp),
        .wr_i  (tag_wr_i)
    );

endmodule

// ==== hw/tmem_ram.sv ====
// Tag memory model with a read bus port, a write side port and a one-cycle acknowledge
`timescale 1ns/1ps

module tmem_ram (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  secv_pkg::tmem_req_t   bus_i,
    output secv_pkg::tmem_rsp_t   bus_o,
    input  secv_pkg::tag_wr_t     wr_i
);

    logic [secv_pkg::TLEN-1:0] tags [2**secv_pkg::ADR_WIDTH];
    logic [secv_pkg::TLEN-1:0] rd_q;
    logic                      ack_q;
    logic                      req;

    assign req = bus_i.cyc && bus_i.stb && !ack_q;

    // Tags start out as zero
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**secv_pkg::ADR_WIDTH; i++) begin
                tags[i] <= '0;
            end
        end else if (wr_i.we) begin
            tags[wr_i.adr] <= wr_i.dat;
        end
    end

    // Read lanes follow the byte selects
    always_ff @(posedge clk_i) begin
        if (req) begin
            for (int i = 0; i < secv_pkg::TSEL_WIDTH; i++) begin
                rd_q[i*8 +: 8] <= bus_i.sel[i] ?
                    tags[bus_i.adr[secv_pkg::ADR_WIDTH-1:0]][i*8 +: 8] : 8'h00;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign bus_o.dat = rd_q;
    assign bus_o.ack = ack_q;

endmodule

// ==== hw/dmem_ram.sv ====
// Data memory model with byte-enabled writes, registered reads and a one-cycle acknowledge
`timescale 1ns/1ps

module dmem_ram (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  secv_pkg::dmem_req_t   bus_i,
    output secv_pkg::dmem_rsp_t   bus_o
);

    logic [secv_pkg::XLEN-1:0] ram [2**secv_pkg::ADR_WIDTH];
    logic [secv_pkg::XLEN-1:0] rd_q;
    logic                      ack_q;
    logic                      req;

    // New request is a strobe not yet acknowledged
    assign req = bus_i.cyc && bus_i.stb && !ack_q;

    always_ff @(posedge clk_i) begin
        if (req && bus_i.we) begin
            for (int i = 0; i < secv_pkg::SEL_WIDTH; i++) begin
                if (bus_i.sel[i]) begin
                    ram[bus_i.adr][i*8 +: 8] <= bus_i.dat[i*8 +: 8];
                end
            end
        end
        if (req) begin
            rd_q <= ram[bus_i.adr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    assign bus_o.dat = rd_q;
    assign bus_o.ack = ack_q;

endmodule

// ==== hw/mem/mem.sv ====
// Memory function unit that checks the pointer tag, then performs the load or store access
`timescale 1ns/1ps

module mem (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  secv_pkg::funit_in_t    fu_i,
    output secv_pkg::funit_out_t   fu_o,
    output logic                   tag_err_o,
    output secv_pkg::dmem_req_t    dmem_o,
    input  secv_pkg::dmem_rsp_t    dmem_i,
    output secv_pkg::tmem_req_t    tmem_o,
    input  secv_pkg::tmem_rsp_t    tmem_i
);

    localparam int XLEN = secv_pkg::XLEN;

    logic                           legal;
    logic                           load;
    logic [secv_pkg::SEL_WIDTH-1:0] sel;
    logic [XLEN-1:0]                st_dat;
    logic [XLEN-1:0]                ld_dat;

    logic tchk_done;
    logic tchk_err;
    logic tag_err;
    logic access;

    // Tag check runs only for legal opcodes
    mtag_chk mtag_chk0 (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .ena_i  (fu_i.ena && legal),
        .adr_i  (fu_i.src1),
        .done_o (tchk_done),
        .err_o  (tchk_err),
        .tmem_o (tmem_o),
        .tmem_i (tmem_i)
    );

    // Opcode decode, store lane placement and load extension
    always_comb begin : decode
        legal  = 1'b1;
        load   = 1'b0;
        sel    = '0;
        st_dat = '0;
        ld_dat = '0;

        case (fu_i.op)
            secv_pkg::MEM_OP_LB: begin
                sel    = 8'h01;
                load   = 1'b1;
                ld_dat = {{(XLEN-8){dmem_i.dat[7]}}, dmem_i.dat[7:0]};
            end
            secv_pkg::MEM_OP_LH: begin
                sel    = 8'h03;
                load   = 1'b1;
                ld_dat = {{(XLEN-16){dmem_i.dat[15]}}, dmem_i.dat[15:0]};
            end
            secv_pkg::MEM_OP_LW: begin
                sel    = 8'h0f;
                load   = 1'b1;
                ld_dat = {{(XLEN-32){dmem_i.dat[31]}}, dmem_i.dat[31:0]};
            end
            secv_pkg::MEM_OP_LD: begin
                sel    = 8'hff;
                load   = 1'b1;
                ld_dat = dmem_i.dat;
            end
            secv_pkg::MEM_OP_LBU: begin
                sel         = 8'h01;
                load        = 1'b1;
                ld_dat[7:0] = dmem_i.dat[7:0];
            end
            secv_pkg::MEM_OP_LHU: begin
                sel          = 8'h03;
                load         = 1'b1;
                ld_dat[15:0] = dmem_i.dat[15:0];
            end
            secv_pkg::MEM_OP_LWU: begin
                sel          = 8'h0f;
                load         = 1'b1;
                ld_dat[31:0] = dmem_i.dat[31:0];
            end
            secv_pkg::MEM_OP_SB: begin
                sel         = 8'h01;
                st_dat[7:0] = fu_i.src2[7:0];
            end
            secv_pkg::MEM_OP_SH: begin
                sel          = 8'h03;
                st_dat[15:0] = fu_i.src2[15:0];
            end
            secv_pkg::MEM_OP_SW: begin
                sel          = 8'h0f;
                st_dat[31:0] = fu_i.src2[31:0];
            end
            secv_pkg::MEM_OP_SD: begin
                sel    = 8'hff;
                st_dat = fu_i.src2;
            end
            default: legal = 1'b0;
        endcase
    end

    assign tag_err = tchk_done && tchk_err;
    // Data access starts once the tag has matched
    assign access  = fu_i.ena && tchk_done && !tchk_err;

    always_comb begin
        dmem_o.cyc = access;
        dmem_o.stb = access;
        dmem_o.sel = sel;
        dmem_o.adr = fu_i.src1[secv_pkg::ADR_WIDTH-1:0];
        dmem_o.we  = access && !load;
        dmem_o.dat = st_dat;
    end

    always_comb begin
        fu_o      = secv_pkg::funit_out_default();
        tag_err_o = 1'b0;

        if (fu_i.ena) begin
            fu_o.rdy    = !legal || dmem_i.ack || tag_err;
            fu_o.err    = !legal || tag_err;
            fu_o.res    = ld_dat;
            fu_o.res_wb = load && dmem_i.ack;
            tag_err_o   = tag_err;
        end
    end

endmodule

// ==== hw/mem/mtag_chk.sv ====
// Tag checker that reads the stored tag for an address and latches match or mismatch
`timescale 1ns/1ps

module mtag_chk (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          ena_i,
    input  logic [secv_pkg::XLEN-1:0]     adr_i,
    output logic                          done_o,
    output logic                          err_o,
    output secv_pkg::tmem_req_t           tmem_o,
    input  secv_pkg::tmem_rsp_t           tmem_i
);

    logic                      done_q;
    logic                      err_q;
    logic [secv_pkg::TLEN-1:0] ptag;

    assign ptag = adr_i[secv_pkg::XLEN-1:secv_pkg::PTAG_LSB];

    // Request stays up until the tag is back
    always_comb begin
        tmem_o.cyc = ena_i && !done_q;
        tmem_o.stb = ena_i && !done_q;
        tmem_o.sel = '1;
        tmem_o.adr = {{(secv_pkg::TADR_WIDTH - secv_pkg::ADR_WIDTH){1'b0}},
                      adr_i[secv_pkg::ADR_WIDTH-1:0]};
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || !ena_i) begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else if (tmem_i.ack && !done_q) begin
            done_q <= 1'b1;
            // Mismatch when stored tag differs from pointer tag
            err_q  <= (tmem_i.dat != ptag);
        end
    end

    assign done_o = done_q;
    assign err_o  = err_q;

endmodule

// ==== common/secv_pkg.sv ====
// Shared widths, memory opcodes and bus structs for the tagged memory unit, used by scoped names
package secv_pkg;

    // Data memory
    localparam int XLEN      = 64;
    localparam int ADR_WIDTH = 8;
    localparam int SEL_WIDTH = 8;

    // Tag memory
    localparam int TLEN       = 16;
    localparam int TADR_WIDTH = 16;
    localparam int TSEL_WIDTH = 2;

    // Pointer tag sits in the upper bits of the address operand
    localparam int PTAG_LSB = 48;

    // Memory opcodes, codes 11 to 15 are illegal
    typedef enum logic [3:0] {
        MEM_OP_LB  = 4'd0,
        MEM_OP_LH  = 4'd1,
        MEM_OP_LW  = 4'd2,
        MEM_OP_LD  = 4'd3,
        MEM_OP_LBU = 4'd4,
        MEM_OP_LHU = 4'd5,
        MEM_OP_LWU = 4'd6,
        MEM_OP_SB  = 4'd7,
        MEM_OP_SH  = 4'd8,
        MEM_OP_SW  = 4'd9,
        MEM_OP_SD  = 4'd10
    } mem_op_t;

    // Function unit request, held by the caller until rdy
    typedef struct packed {
        logic            ena;
        mem_op_t         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } funit_in_t;

    typedef struct packed {
        logic            rdy;
        logic            err;
        logic [XLEN-1:0] res;
        logic            res_wb;
    } funit_out_t;

    // Wishbone-style data bus
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic [SEL_WIDTH-1:0] sel;
        logic [ADR_WIDTH-1:0] adr;
        logic                 we;
        logic [XLEN-1:0]      dat;
    } dmem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] dat;
        logic            ack;
    } dmem_rsp_t;

    // Tag bus, read only
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic [TSEL_WIDTH-1:0] sel;
        logic [TADR_WIDTH-1:0] adr;
    } tmem_req_t;

    typedef struct packed {
        logic [TLEN-1:0] dat;
        logic            ack;
    } tmem_rsp_t;

    // Side port for tag writes
    typedef struct packed {
        logic                 we;
        logic [ADR_WIDTH-1:0] adr;
        logic [TLEN-1:0]      dat;
    } tag_wr_t;

    function automatic funit_out_t funit_out_default();
        funit_out_t out;
        out = '0;
        return out;
    endfunction

endpackage
